// File: Makefile
VERILATOR = verilator
TOP = tbProc
FLIST = flist.f
VFLAGS = --binary --timing --assert -j 0
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# Exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/fetch.sv
logic/hazardUnit.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/proc.sv
sim/tbProc.sv

// File: logic/decode.sv
`timescale 1ns/1ps
`include "proc_consts.svh"

module decode
	import isaPkg::*, pipePkg::*;
(
	input  logic clk,
	input  logic rstN,
	input  ifIdT ifId,
	input  memWbT wb,
	input  logic stall,
	output logic [$clog2(`REG_COUNT)-1:0] rs,
	output logic [$clog2(`REG_COUNT)-1:0] rt,
	output logic usesRs,
	output logic usesRt,
	output logic redirect,
	output logic [`WORD_W-1:0] target,
	output logic stopFetch,
	output idExT idEx,
	output logic err
);

	logic [`WORD_W-1:0] regs [`REG_COUNT];
	instrU ins;
	ctrlT ctrl;
	regSelT destReg;
	logic [`WORD_W-1:0] rsData;
	logic [`WORD_W-1:0] rtData;
	logic [`WORD_W-1:0] imm5Ext;
	logic [`WORD_W-1:0] imm8Ext;
	logic [`WORD_W-1:0] disp11Ext;
	logic useImm;
	logic isBranch;
	logic isJump;
	logic illegal;
	logic haltSeen;
	logic errSeen;

	assign ins = ifId.instr;
	assign imm5Ext = {{(`WORD_W-5){ins.iFmt.imm5[4]}}, ins.iFmt.imm5};
	assign imm8Ext = {{(`WORD_W-8){ins.bFmt.imm8[7]}}, ins.bFmt.imm8};
	assign disp11Ext = {{(`WORD_W-11){ins.jFmt.disp11[10]}}, ins.jFmt.disp11};

	always_comb begin
		ctrl = '0;
		destReg = ins.iFmt.rd;
		rt = ins.rFmt.rt; // Same bits as rd of a store
		usesRs = 1'b0;
		usesRt = 1'b0;
		useImm = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		illegal = 1'b0;
		if (ifId.valid) begin
			case (ins.rFmt.opcode)
				opHalt: ctrl.isHalt = 1'b1;
				opNop: ;
				opJ: isJump = 1'b1;
				opAddi: begin
					ctrl.regWrite = 1'b1;
					usesRs = 1'b1;
					useImm = 1'b1;
				end
				opBeqz: begin
					usesRs = 1'b1;
					isBranch = 1'b1;
				end
				opSt: begin
					ctrl.memWrite = 1'b1;
					usesRs = 1'b1;
					usesRt = 1'b1;
					useImm = 1'b1;
				end
				opLd: begin
					ctrl.memRead = 1'b1;
					ctrl.regWrite = 1'b1;
					usesRs = 1'b1;
					useImm = 1'b1;
				end
				opRtype: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluOp = ins.rFmt.func;
					destReg = ins.rFmt.rd;
					usesRs = 1'b1;
					usesRt = 1'b1;
				end
				default: illegal = 1'b1;
			endcase
		end
	end

	assign rs = ins.rFmt.rs;

	// Write before read
	assign rsData = (wb.regWrite && wb.destReg == rs) ? wb.result : regs[rs];
	assign rtData = (wb.regWrite && wb.destReg == rt) ? wb.result : regs[rt];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb.regWrite) begin
			regs[wb.destReg] <= wb.result;
		end
	end

	// A stalled BEQZ may be looking at a stale rs
	assign redirect = !stall && (isJump || (isBranch && rsData == '0));
	assign target = ifId.pc2 + (isJump ? disp11Ext : imm8Ext);

	assign stopFetch = haltSeen || ctrl.isHalt;
	assign err = errSeen || illegal;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			haltSeen <= 1'b0;
			errSeen <= 1'b0;
			idEx.ctrl <= '0;
		end else begin
			haltSeen <= stopFetch;
			errSeen <= err;
			idEx.ctrl <= stall ? '0 : ctrl; // Bubble while stalled
			idEx.opA <= rsData;
			idEx.opB <= useImm ? imm5Ext : rtData;
			idEx.storeData <= rtData;
			idEx.destReg <= destReg;
		end
	end

	// A taken redirect flushes fetch instead of being held by a stall
	redirectFlushes: assert property (@(posedge clk) disable iff (!rstN)
		redirect |=> (!ifId.valid && ifId.instr == `NOP_WORD))
		else $error("Redirect did not flush IF/ID");

endmodule

// File: logic/execute.sv
`timescale 1ns/1ps
`include "proc_consts.svh"

module execute
	import isaPkg::*, pipePkg::*;
(
	input  logic clk,
	input  logic rstN,
	input  idExT idEx,
	output exMemT exMem,
	output logic [$clog2(`REG_COUNT)-1:0] dest,
	output logic regWrite
);

	logic [`WORD_W-1:0] aluRes;

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluAdd: aluRes = idEx.opA + idEx.opB; // Also address for LD and ST
			aluSub: aluRes = idEx.opA - idEx.opB;
			aluXor: aluRes = idEx.opA ^ idEx.opB;
			aluAnd: aluRes = idEx.opA & idEx.opB;
			default: aluRes = idEx.opA + idEx.opB;
		endcase
	end

	// Seen by the hazard unit
	assign dest = idEx.destReg;
	assign regWrite = idEx.ctrl.regWrite;

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			exMem.ctrl <= '0;
		end else begin
			exMem.ctrl <= idEx.ctrl;
			exMem.aluRes <= aluRes;
			exMem.storeData <= idEx.storeData;
			exMem.destReg <= idEx.destReg;
		end
	end

endmodule

// File: logic/fetch.sv
`timescale 1ns/1ps
`include "proc_consts.svh"

module fetch
	import pipePkg::*;
(
	input  logic clk,
	input  logic rstN,
	input  progT prog,
	input  logic stall,
	input  logic redirect,
	input  logic [`WORD_W-1:0] target,
	input  logic stopFetch,
	output ifIdT ifId
);

	localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

	logic [`WORD_W-1:0] imem [`IMEM_DEPTH];
	logic [`WORD_W-1:0] pc;
	logic [`WORD_W-1:0] pc2;
	logic [`WORD_W-1:0] fetched;
	logic squash;

	assign pc2 = pc + `WORD_W'd2;
	assign fetched = imem[pc[IMEM_AW:1]];
	assign squash = redirect || stopFetch; // Wrong path or past HALT

	// Loaded only while the core is held in reset
	always_ff @(posedge clk) begin
		if (!rstN && prog.en)
			imem[prog.addr[IMEM_AW:1]] <= prog.data;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (!stall) begin
			if (redirect)
				pc <= target;
			else if (!stopFetch)
				pc <= pc2;
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			ifId.instr <= `NOP_WORD;
			ifId.valid <= 1'b0;
		end else if (!stall) begin
			ifId.pc2 <= pc2;
			ifId.instr <= squash ? `NOP_WORD : fetched;
			ifId.valid <= !squash;
		end
	end

	// Branch and jump offsets from decode must keep word alignment
	pcEven: assert property (@(posedge clk) disable iff (!rstN) pc[0] == 1'b0)
		else $error("PC became odd");

endmodule

// File: logic/hazardUnit.sv
`timescale 1ns/1ps
`include "proc_consts.svh"

module hazardUnit (
	input  logic [$clog2(`REG_COUNT)-1:0] rs,
	input  logic [$clog2(`REG_COUNT)-1:0] rt,
	input  logic usesRs,
	input  logic usesRt,
	input  logic [$clog2(`REG_COUNT)-1:0] exDest,
	input  logic exRegWrite,
	input  logic [$clog2(`REG_COUNT)-1:0] memDest,
	input  logic memRegWrite,
	output logic stall
);

	logic rsHit;
	logic rtHit;

	// Writeback is covered by the register file bypass
	assign rsHit = usesRs &&
		((exRegWrite && rs == exDest) || (memRegWrite && rs == memDest));
	assign rtHit = usesRt &&
		((exRegWrite && rt == exDest) || (memRegWrite && rt == memDest));

	assign stall = rsHit || rtHit;

	// No clock here, so checked once the inputs settle
	always_comb begin
		useFlagsKnown: assert final (!(stall && $isunknown({usesRs, usesRt})))
			else $error("Stall raised on unknown use flags");
	end

endmodule

// File: logic/isaPkg.sv
package isaPkg;

	typedef enum logic [4:0] {
		opHalt  = 5'b00000,
		opNop   = 5'b00001,
		opJ     = 5'b00100,
		opAddi  = 5'b01000,
		opBeqz  = 5'b01100,
		opSt    = 5'b10000,
		opLd    = 5'b10001,
		opRtype = 5'b11011
	} opcodeE;

	// Also the func field of RTYPE
	typedef enum logic [1:0] {
		aluAdd = 2'b00,
		aluSub = 2'b01,
		aluXor = 2'b10,
		aluAnd = 2'b11
	} aluOpE;

	typedef struct packed {
		opcodeE opcode;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		aluOpE func;
	} rFmtT;

	typedef struct packed {
		opcodeE opcode;
		logic [2:0] rs;
		logic [2:0] rd;
		logic [4:0] imm5;
	} iFmtT;

	typedef struct packed {
		opcodeE opcode;
		logic [2:0] rs;
		logic [7:0] imm8;
	} bFmtT;

	typedef struct packed {
		opcodeE opcode;
		logic [10:0] disp11;
	} jFmtT;

	// Same 16 bits, read through whichever format the opcode calls for
	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
		bFmtT bFmt;
		jFmtT jFmt;
	} instrU;

endpackage

// File: logic/memory.sv
`timescale 1ns/1ps
`include "proc_consts.svh"

module memory
	import pipePkg::*;
(
	input  logic clk,
	input  logic rstN,
	input  exMemT exMem,
	output memWbT memWb,
	output logic halted,
	output logic [$clog2(`REG_COUNT)-1:0] dest,
	output logic regWrite
);

	localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

	logic [`WORD_W-1:0] dmem [`DMEM_DEPTH];
	logic [`WORD_W-1:0] loadData;
	logic haltSeen;

	assign loadData = dmem[exMem.aluRes[DMEM_AW:1]];

	always_ff @(posedge clk) begin
		if (exMem.ctrl.memWrite)
			dmem[exMem.aluRes[DMEM_AW:1]] <= exMem.storeData;
	end

	assign dest = exMem.destReg;
	assign regWrite = exMem.ctrl.regWrite;

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			memWb.regWrite <= 1'b0;
			memWb.isHalt <= 1'b0;
			haltSeen <= 1'b0;
		end else begin
			memWb.regWrite <= exMem.ctrl.regWrite;
			memWb.isHalt <= exMem.ctrl.isHalt;
			memWb.destReg <= exMem.destReg;
			memWb.result <= exMem.ctrl.memRead ? loadData : exMem.aluRes;
			haltSeen <= halted;
		end
	end

	assign halted = haltSeen || memWb.isHalt; // Sticky from HALT's writeback

	loadXorStore: assert property (@(posedge clk) disable iff (!rstN)
		!(exMem.ctrl.memRead && exMem.ctrl.memWrite))
		else $error("Load and store in the same slot");

endmodule

// File: logic/pipePkg.sv
`include "proc_consts.svh"

package pipePkg;
	import isaPkg::*;

	typedef logic [$clog2(`REG_COUNT)-1:0] regSelT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isHalt;
		aluOpE aluOp;
	} ctrlT;

	typedef struct packed {
		logic [`WORD_W-1:0] pc2; // PC plus 2
		instrU instr;
		logic valid;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		logic [`WORD_W-1:0] opA;
		logic [`WORD_W-1:0] opB; // rt value or extended immediate
		logic [`WORD_W-1:0] storeData;
		regSelT destReg;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		logic [`WORD_W-1:0] aluRes;
		logic [`WORD_W-1:0] storeData;
		regSelT destReg;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic isHalt;
		regSelT destReg;
		logic [`WORD_W-1:0] result;
	} memWbT;

	// One register write seen at writeback
	typedef struct packed {
		logic valid;
		regSelT regSel;
		logic [`WORD_W-1:0] data;
	} wbT;

	// Byte address, same word indexing as the PC
	typedef struct packed {
		logic en;
		logic [`WORD_W-1:0] addr;
		logic [`WORD_W-1:0] data;
	} progT;

endpackage

// File: logic/proc.sv
`timescale 1ns/1ps
`include "proc_consts.svh"

module proc
	import pipePkg::*;
(
	input  logic clk,
	input  logic rstN,
	input  progT prog,
	output wbT wb,
	output logic halted,
	output logic err
);

	ifIdT ifId;
	idExT idEx;
	exMemT exMem;
	memWbT memWb;
	logic stall;
	logic redirect;
	logic stopFetch;
	logic [`WORD_W-1:0] target;
	regSelT rs;
	regSelT rt;
	logic usesRs;
	logic usesRt;
	regSelT exDest;
	logic exRegWrite;
	regSelT memDest;
	logic memRegWrite;

	fetch fetch0 (.clk, .rstN, .prog, .stall, .redirect, .target, .stopFetch, .ifId);

	hazardUnit hazard0 (.rs, .rt, .usesRs, .usesRt, .exDest, .exRegWrite,
		.memDest, .memRegWrite, .stall);

	decode decode0 (.clk, .rstN, .ifId, .wb(memWb), .stall, .rs, .rt, .usesRs, .usesRt,
		.redirect, .target, .stopFetch, .idEx, .err);

	execute execute0 (.clk, .rstN, .idEx, .exMem, .dest(exDest), .regWrite(exRegWrite));

	memory memory0 (.clk, .rstN, .exMem, .memWb, .halted, .dest(memDest),
		.regWrite(memRegWrite));

	// Writeback trace
	assign wb.valid = memWb.regWrite;
	assign wb.regSel = memWb.destReg;
	assign wb.data = memWb.result;

endmodule

// File: logic/proc_consts.svh
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

`define WORD_W     16
`define REG_COUNT  8
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256
`define NOP_WORD   16'h0800 // Opcode 00001, all fields zero

`endif

// File: sim/tbProc.sv
`timescale 1ns/1ps
`include "proc_consts.svh"

module tbProc
	import isaPkg::*, pipePkg::*;
();

	localparam int CYCLE_LIMIT = 1500; // Five tests, 300 cycles each at most
	localparam logic [15:0] HALT_WORD = 16'h0000;
	localparam logic [15:0] ILLEGAL_WORD = 16'hF800; // Opcode 11111 is unused

	logic clk = 1'b0;
	logic rstN;
	progT prog;
	wbT wb;
	logic halted;
	logic err;
	logic [15:0] lfsr = 16'd9;
	int cycles = 0;
	logic [`WORD_W-1:0] progWords[$];
	wbT seen[$];
	wbT expected[$];

	proc dut (.clk, .rstN, .prog, .wb, .halted, .err);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			abortRun($sformatf("Timeout: tests still running after %0d cycles", cycles));
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	task automatic checkWb(input wbT got, input wbT exp, input string name);
		if (got !== exp)
			abortRun($sformatf(
				"CHECK FAILED at %0t: %s got r%0d=%h valid %b, expected r%0d=%h valid %b",
				$time, name, got.regSel, got.data, got.valid,
				exp.regSel, exp.data, exp.valid));
	endtask

	task automatic checkBit(input logic got, input logic exp, input string name);
		if (got !== exp)
			abortRun($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];
		lfsr = {fb, lfsr[15:1]};
		return lfsr[0];
	endfunction

	function automatic logic [4:0] randImm5();
		logic [4:0] v;
		v = '0;
		for (int i = 0; i < 5; i++)
			v = {v[3:0], lfsrBit()};
		return v;
	endfunction

	function automatic logic [15:0] sext5(input logic [4:0] imm);
		return {{11{imm[4]}}, imm};
	endfunction

	// ADDI, LD and ST share the I layout
	function automatic logic [15:0] encI(input opcodeE op, input logic [2:0] rd,
		input logic [2:0] rs, input logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] encR(input aluOpE f, input logic [2:0] rd,
		input logic [2:0] rs, input logic [2:0] rt);
		return {opRtype, rs, rt, rd, f};
	endfunction

	function automatic wbT wbOf(input logic [2:0] r, input logic [15:0] v);
		wbT w;
		w.valid = 1'b1;
		w.regSel = r;
		w.data = v;
		return w;
	endfunction

	// Load during reset, then trace writebacks until halted
	task automatic runProgram(input logic expErr);
		seen.delete();
		@(posedge clk);
		#1;
		rstN = 1'b0;
		for (int i = 0; i < 5 || i < progWords.size(); i++) begin
			prog.en = i < progWords.size();
			prog.addr = 16'(2 * i);
			prog.data = (i < progWords.size()) ? progWords[i] : '0;
			@(posedge clk);
			#1;
		end
		prog = '0;
		rstN = 1'b1;
		do begin
			@(negedge clk);
			if (wb.valid)
				seen.push_back(wb);
			if (!expErr)
				checkBit(err, 1'b0, "err");
		end while (!halted);
		repeat (8) begin // Nothing may retire after HALT
			@(negedge clk);
			if (wb.valid)
				abortRun($sformatf("Writeback to r%0d at %0t after halt", wb.regSel, $time));
			checkBit(halted, 1'b1, "halted");
			checkBit(err, expErr, "err");
		end
	endtask

	task automatic compareTrace();
		for (int i = 0; i < seen.size() && i < expected.size(); i++)
			checkWb(seen[i], expected[i], $sformatf("wb write %0d", i));
		if (seen.size() < expected.size())
			abortRun($sformatf("Missing writebacks: saw %0d of %0d",
				seen.size(), expected.size()));
		else if (seen.size() > expected.size())
			abortRun($sformatf("Extra writebacks: saw %0d, wanted %0d",
				seen.size(), expected.size()));
	endtask

	task automatic aluChainTest();
		logic [4:0] a;
		logic [4:0] b;
		logic [4:0] c;
		logic [15:0] r1, r2, r3, r4, r5, r6, r7;
		a = randImm5();
		b = randImm5();
		c = randImm5();
		r1 = sext5(a);
		r2 = r1 + sext5(b);
		r3 = r2 + sext5(c);
		r4 = r2 + r3;
		r5 = r4 - r1;
		r6 = r5 ^ r2;
		r7 = r6 & r4;
		progWords = '{encI(opAddi, 3'd1, 3'd0, a), encI(opAddi, 3'd2, 3'd1, b),
			encI(opAddi, 3'd3, 3'd2, c), encR(aluAdd, 3'd4, 3'd2, 3'd3),
			encR(aluSub, 3'd5, 3'd4, 3'd1), encR(aluXor, 3'd6, 3'd5, 3'd2),
			encR(aluAnd, 3'd7, 3'd6, 3'd4), HALT_WORD};
		expected = '{wbOf(3'd1, r1), wbOf(3'd2, r2), wbOf(3'd3, r3), wbOf(3'd4, r4),
			wbOf(3'd5, r5), wbOf(3'd6, r6), wbOf(3'd7, r7)};
		runProgram(1'b0);
		compareTrace();
	endtask

	task automatic storeLoadTest();
		logic [4:0] a;
		logic [4:0] b;
		logic [15:0] sum;
		a = randImm5();
		b = randImm5();
		sum = sext5(a) + sext5(b);
		// Store to 6 + 4, load back from 0 + 10
		progWords = '{encI(opAddi, 3'd1, 3'd0, a), encI(opAddi, 3'd2, 3'd0, b),
			encR(aluAdd, 3'd3, 3'd1, 3'd2), encI(opAddi, 3'd4, 3'd0, 5'd6),
			encI(opSt, 3'd3, 3'd4, 5'd4), encI(opLd, 3'd5, 3'd0, 5'd10), HALT_WORD};
		expected = '{wbOf(3'd1, sext5(a)), wbOf(3'd2, sext5(b)), wbOf(3'd3, sum),
			wbOf(3'd4, 16'd6), wbOf(3'd5, sum)};
		runProgram(1'b0);
		compareTrace();
	endtask

	task automatic branchTest();
		progWords = '{encI(opAddi, 3'd1, 3'd0, 5'd0), encI(opAddi, 3'd2, 3'd0, 5'd5),
			{opBeqz, 3'd1, 8'd4}, // Taken, lands on byte 10
			encI(opAddi, 3'd3, 3'd0, 5'd1), encI(opAddi, 3'd4, 3'd0, 5'd2),
			{opBeqz, 3'd2, 8'd2}, // Not taken
			encI(opAddi, 3'd5, 3'd0, 5'd3),
			{opJ, 11'd4}, // Lands on byte 20
			encI(opAddi, 3'd6, 3'd0, 5'd4), encI(opAddi, 3'd7, 3'd0, 5'd5),
			encI(opAddi, 3'd7, 3'd0, 5'd7), HALT_WORD};
		expected = '{wbOf(3'd1, 16'd0), wbOf(3'd2, 16'd5), wbOf(3'd5, 16'd3),
			wbOf(3'd7, 16'd7)};
		runProgram(1'b0);
		compareTrace();
	endtask

	task automatic haltTest();
		logic [4:0] a;
		logic [4:0] b;
		a = randImm5();
		b = randImm5();
		progWords = '{encI(opAddi, 3'd1, 3'd0, a), encI(opAddi, 3'd2, 3'd1, b),
			encI(opAddi, 3'd3, 3'd0, 5'd9), HALT_WORD,
			encI(opAddi, 3'd4, 3'd0, 5'd1), encI(opAddi, 3'd5, 3'd0, 5'd2)};
		expected = '{wbOf(3'd1, sext5(a)), wbOf(3'd2, sext5(a) + sext5(b)),
			wbOf(3'd3, 16'd9)};
		runProgram(1'b0);
		compareTrace();
	endtask

	task automatic illegalOpTest();
		logic [4:0] a;
		a = randImm5();
		progWords = '{encI(opAddi, 3'd1, 3'd0, a), ILLEGAL_WORD, HALT_WORD};
		expected = '{wbOf(3'd1, sext5(a))};
		runProgram(1'b1);
		compareTrace();
	endtask

	initial begin
		rstN = 1'b0;
		prog = '0;
		aluChainTest();
		storeLoadTest();
		branchTest();
		haltTest();
		illegalOpTest();
		$display("Test passed");
		$finish;
	end

endmodule
